// ==== Bender.yml ====
package:
  name: snes_cart

export_include_dirs:
  - .

sources:
  - files:
      - snes_cart_pkg.sv
      - cart_header_detect.sv
      - cheat_code_loader.sv
      - ram_clear_engine.sv
      - backup_sector_seq.sv
      - snes_cart_top.sv
  - target: test
    files:
      - snes_cart_checker.sv
      - snes_cart_tb.sv

// ==== backup_sector_seq.sv ====
// Loads and saves battery-backed RAM one 512-byte sector at a time.
// Each sector is a sd_rd or sd_wr request closed by the host's sd_ack pulse.

`default_nettype none

`include "snes_cart_settings.svh"

module backup_sector_seq (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_dl,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic [7:0]              rom_type,
	input  logic [`SNES_MASK_W-1:0] ram_mask,
	input  logic                    bk_load_req,
	input  logic                    bk_save_req,
	input  logic                    sd_ack,
	output logic                    bk_ena,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic [31:0]             sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr
);

	logic        cart_dl_q;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        sufami;
	logic [31:0] lba_end;
	logic        load_rise;
	logic        save_rise;
	logic        auto_load;

	// Sufami Turbo with a second cart holds twice the RAM
	assign sufami = (rom_type[7:4] == 4'h2) && rom_type[3];
	assign lba_end = sufami ?
		32'({ram_mask[`SNES_MASK_W-1:`SNES_SECTOR_LSB], 1'b1}) :
		32'(ram_mask[`SNES_MASK_W-1:`SNES_SECTOR_LSB]);

	assign load_rise = bk_load_req & bk_ena & ~load_q;
	assign save_rise = bk_save_req & bk_ena & ~save_q;
	// Save file is mounted by the time the download ends
	assign auto_load = cart_dl_q & ~cart_dl & (|img_size) & bk_ena;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q <= 1'b0;
			bk_ena <= 1'b0;
			bk_busy <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba <= '0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			load_q <= bk_load_req & bk_ena;
			save_q <= bk_save_req & bk_ena;
			ack_q <= sd_ack;

			// Backup enable
			if (cart_dl && !cart_dl_q)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			// Host took the request
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_rise || save_rise) begin
					bk_busy <= 1'b1;
					bk_loading <= load_rise;
					sd_lba <= '0;
					sd_rd <= load_rise;
					sd_wr <= ~load_rise;
				end
				if (auto_load) begin
					bk_busy <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba <= '0;
					sd_rd <= 1'b1;
					sd_wr <= 1'b0;
				end
			end else if (!sd_ack && ack_q) begin
				// Sector done, move on or finish
				if (sd_lba >= lba_end) begin
					bk_busy <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd <= bk_loading;
					sd_wr <= ~bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== cart_header_detect.sv ====
// Watches the cartridge download for the size, type and region bytes.
// Sizes become address masks for ROM and backup RAM; the region drives pal.

`default_nettype none

`include "snes_cart_settings.svh"

module cart_header_detect (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         cart_dl,
	input  logic                         ioctl_wr,
	input  logic [`SNES_IO_ADDR_W-1:0]   ioctl_addr,
	input  logic [`SNES_IO_DATA_W-1:0]   ioctl_dout,
	input  snes_cart_pkg::hdr_mode_t     header_mode,
	input  logic [1:0]                   region_sel,
	output logic [7:0]                   rom_type,
	output logic [`SNES_MASK_W-1:0]      rom_mask,
	output logic [`SNES_MASK_W-1:0]      ram_mask,
	output logic                         pal
);

	logic                       hdr_wr;
	logic                       hdr_fixed;
	logic [`SNES_IO_ADDR_W-1:0] rom_size_at;
	logic [`SNES_IO_ADDR_W-1:0] ram_size_at;
	logic [3:0]                 rom_size;
	logic [3:0]                 ram_size;
	logic [3:0]                 rom_size_nxt;
	logic [3:0]                 ram_size_nxt;
	logic                       rom_region;

	assign hdr_wr = cart_dl & ioctl_wr;

	// Where the internal header lands, past the copier block
	always_comb begin
		hdr_fixed = 1'b1;
		rom_size_at = `SNES_IO_ADDR_W'(`SNES_HDR_LO + `SNES_COPIER_HDR);
		case (header_mode)
			snes_cart_pkg::hdr_lorom:
				rom_size_at = `SNES_IO_ADDR_W'(`SNES_HDR_LO + `SNES_COPIER_HDR);
			snes_cart_pkg::hdr_hirom:
				rom_size_at = `SNES_IO_ADDR_W'(`SNES_HDR_HI + `SNES_COPIER_HDR);
			snes_cart_pkg::hdr_exhirom:
				rom_size_at = `SNES_IO_ADDR_W'(`SNES_HDR_EX + `SNES_COPIER_HDR);
			default:
				hdr_fixed = 1'b0;
		endcase
		ram_size_at = rom_size_at + `SNES_IO_ADDR_W'(2);
	end

	// Sizes after this word, so the masks follow in the same cycle
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size_nxt = 4'hC;
				ram_size_nxt = 4'h0;
				if (header_mode == snes_cart_pkg::hdr_auto && ioctl_dout[7:0] != 8'h00)
					{ram_size_nxt, rom_size_nxt} = ioctl_dout[7:0];
			end
			if (hdr_fixed) begin
				if (ioctl_addr == rom_size_at)
					rom_size_nxt = ioctl_dout[11:8];
				if (ioctl_addr == ram_size_at)
					ram_size_nxt = ioctl_dout[3:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size <= 4'h0;
			ram_size <= 4'h0;
			rom_region <= 1'b0;
			rom_type <= 8'h00;
			rom_mask <= '0;
			ram_mask <= '0;
			pal <= 1'b0;
		end else begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
			if (hdr_wr) begin
				if (ioctl_addr == '0) begin
					case (header_mode)
						snes_cart_pkg::hdr_none,
						snes_cart_pkg::hdr_lorom:   rom_type <= 8'h00;
						snes_cart_pkg::hdr_hirom:   rom_type <= 8'h01;
						snes_cart_pkg::hdr_exhirom: rom_type <= 8'h02;
						default:                    rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == `SNES_IO_ADDR_W'(2))
					rom_region <= ioctl_dout[8];
				rom_mask <= (`SNES_MASK_W'(1024) << rom_size_nxt) - `SNES_MASK_W'(1);
				ram_mask <= (ram_size_nxt != 4'h0) ?
					(`SNES_MASK_W'(1024) << ram_size_nxt) - `SNES_MASK_W'(1) : '0;
			end
			// Region select 0 means follow the cartridge
			if (!cart_dl)
				pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

`default_nettype wire

// ==== cheat_code_loader.sv ====
// Collects the eight words of one cheat code from the code download.
// cheat_strobe pulses for one cycle once the last slot has been written.

`default_nettype none

`include "snes_cart_settings.svh"

module cheat_code_loader (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       code_dl,
	input  logic                       ioctl_wr,
	input  logic [3:0]                 ioctl_addr,
	input  logic [`SNES_IO_DATA_W-1:0] ioctl_dout,
	output snes_cart_pkg::cheat_code_t cheat_code,
	output logic                       cheat_strobe
);

	logic       slot_wr;
	logic [2:0] slot;

	// Byte address 2k selects slot k, odd addresses are ignored
	assign slot = ioctl_addr[3:1];
	assign slot_wr = code_dl & ioctl_wr & ~ioctl_addr[0];

	// Code words
	always_ff @(posedge clk_sys) begin
		if (slot_wr)
			cheat_code.words[slot] <= ioctl_dout;
	end

	// Slot 7 completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= slot_wr && (slot == 3'd7);
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
snes_cart_pkg.sv
cart_header_detect.sv
cheat_code_loader.sv
ram_clear_engine.sv
backup_sector_seq.sv
snes_cart_top.sv
snes_cart_checker.sv
snes_cart_tb.sv

// ==== ram_clear_engine.sv ====
// Sweeps the work RAM address space once after a cartridge download starts.
// A write slot on every second cycle, with the byte set by fill_pattern.

`default_nettype none

`include "snes_cart_settings.svh"

module ram_clear_engine #(
	parameter int FILL_BITS = `SNES_FILL_BITS
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_dl,
	input  logic [1:0]           fill_pattern,
	output logic                 clearing,
	output logic                 fill_we,
	output logic [FILL_BITS-1:0] fill_addr,
	output logic [7:0]           fill_data
);

	logic cart_dl_q;
	logic fill_wait;

	// ==================================================
	// Sweep control
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			clearing <= 1'b0;
			fill_wait <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (clearing) begin
				fill_wait <= ~fill_wait;
				if (fill_wait)
					fill_addr <= fill_addr + 1'b1;
				// Last address gets its write this cycle
				if (&fill_addr)
					clearing <= 1'b0;
			end else begin
				fill_wait <= 1'b0;
				fill_addr <= '0;
				if (cart_dl && !cart_dl_q)
					clearing <= 1'b1;
			end
		end
	end

	assign fill_we = clearing & ~fill_wait;

	// ==================================================
	// Fill byte
	// ==================================================

	// Patterns follow the power-on contents of real consoles
	always_comb begin
		case (fill_pattern)
			2'd0: fill_data = (fill_addr[8] ^ fill_addr[2]) ? `SNES_FILL_A : `SNES_FILL_B;
			2'd1: fill_data = (fill_addr[9] ^ fill_addr[0]) ? `SNES_FILL_FF : 8'h00;
			2'd2: fill_data = `SNES_FILL_55;
			default: fill_data = `SNES_FILL_FF;
		endcase
	end

endmodule

`default_nettype wire

// ==== snes_cart_checker.sv ====
// Protocol assertions for the cartridge ingest top, attached with bind.
// fail_count is read by the testbench for the final verdict.

`default_nettype none

`include "snes_cart_settings.svh"

module snes_cart_checker (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    clearing,
	input  logic                    fill_we,
	input  logic                    cheat_strobe,
	input  logic                    bk_busy,
	input  logic                    sd_rd,
	input  logic                    sd_wr,
	input  logic [31:0]             sd_lba,
	input  logic [7:0]              rom_type,
	input  logic [`SNES_MASK_W-1:0] ram_mask
);

	int          fail_count = 0;
	logic        sufami;
	logic [31:0] lba_last;

	// Sufami type doubles the backup size
	assign sufami = (rom_type[7:4] == 4'h2) && rom_type[3];
	assign lba_last = sufami ? 32'({ram_mask[23:9], 1'b1}) : 32'(ram_mask[23:9]);

	// Each write slot sits in a sweep and is followed by a wait cycle
	fill_only_while_clearing: assert property (
		@(posedge clk_sys) disable iff (RESET) fill_we |-> clearing ##1 !fill_we
	) else begin
		fail_count++;
		$error("fill_we outside a clear sweep or on two cycles in a row");
	end

	one_sector_request: assert property (
		@(posedge clk_sys) disable iff (RESET) !(sd_rd && sd_wr)
	) else begin
		fail_count++;
		$error("sd_rd and sd_wr high together");
	end

	strobe_single_cycle: assert property (
		@(posedge clk_sys) disable iff (RESET) cheat_strobe |=> !cheat_strobe
	) else begin
		fail_count++;
		$error("cheat_strobe high for two cycles");
	end

	lba_in_range: assert property (
		@(posedge clk_sys) disable iff (RESET) bk_busy |-> (sd_lba <= lba_last)
	) else begin
		fail_count++;
		$error("sd_lba past the last backup sector");
	end

endmodule

bind snes_cart_top snes_cart_checker u_checker (
	.clk_sys(clk_sys), .RESET(RESET), .clearing(clearing), .fill_we(fill_we),
	.cheat_strobe(cheat_strobe), .bk_busy(bk_busy), .sd_rd(sd_rd), .sd_wr(sd_wr),
	.sd_lba(sd_lba), .rom_type(rom_type), .ram_mask(ram_mask)
);

`default_nettype wire

// ==== snes_cart_pkg.sv ====
// Types shared by the cartridge ingest blocks.
// Referenced by scoped names from the RTL and the testbench.

`default_nettype none

`include "snes_cart_settings.svh"

package snes_cart_pkg;

	// What the host is currently streaming
	typedef enum logic [2:0] {
		dl_none,
		dl_cart,
		dl_spc,
		dl_code,
		dl_other
	} dl_kind_t;

	// ROM header option, mode numbers 0 to 4
	typedef enum logic [2:0] {
		hdr_auto = 3'd0,
		hdr_none = 3'd1,
		hdr_lorom = 3'd2,
		hdr_hirom = 3'd3,
		hdr_exhirom = 3'd4
	} hdr_mode_t;

	// Cheat code, loaded as word slots and read as fields
	// Slot k sits in words[k], so each field pairs an odd slot over an even one
	typedef union packed {
		logic [7:0][`SNES_IO_DATA_W-1:0] words;
		struct packed {
			logic [31:0] replace;
			logic [31:0] compare;
			logic [31:0] addr;
			logic [31:0] flags;
		} fields;
	} cheat_code_t;

	// Index 0xFF is the code stream, low six bits pick the rest
	function automatic dl_kind_t download_kind(input logic download, input logic [7:0] index);
		dl_kind_t kind;
		if (!download)
			kind = dl_none;
		else if (&index)
			kind = dl_code;
		else if (index[5:0] == 6'd0)
			kind = dl_cart;
		else if (index[5:0] == 6'd1)
			kind = dl_spc;
		else
			kind = dl_other;
		return kind;
	endfunction

endpackage

`default_nettype wire

// ==== snes_cart_settings.svh ====
// Shared widths, constants and header offsets for the cartridge ingest path.
// Include this file in any source file that uses one of these macros.

`ifndef SNES_CART_SETTINGS_SVH
`define SNES_CART_SETTINGS_SVH

// Download bus
`define SNES_IO_ADDR_W 25
`define SNES_IO_DATA_W 16

// ROM and backup RAM masks
`define SNES_MASK_W 24

// Default clear sweep covers 256 KB
`define SNES_FILL_BITS 18

// Copier header sits in front of the ROM image
`define SNES_COPIER_HDR 32'h200

// Internal header bases, RAM size byte is 2 above each base
`define SNES_HDR_LO 32'h7FD6
`define SNES_HDR_HI 32'hFFD6
`define SNES_HDR_EX 32'h40FFD6

// Power-on fill bytes
`define SNES_FILL_A 8'h66
`define SNES_FILL_B 8'h99
`define SNES_FILL_55 8'h55
`define SNES_FILL_FF 8'hFF

// Backup sectors are 512 bytes
`define SNES_SECTOR_LSB 9

`endif

// ==== snes_cart_tb.sv ====
// Testbench for the cartridge ingest top.
// Streams downloads, answers sector requests and checks the results.
// Protocol assertions come from the bound checker.

`default_nettype none

`include "snes_cart_settings.svh"

module snes_cart_tb;

	localparam int FILL_BITS = 10;
	localparam int SWEEP_LIMIT = 4 << FILL_BITS;

	logic                       clk_sys = 1'b0;
	logic                       RESET;
	logic                       ioctl_download;
	logic [7:0]                 ioctl_index;
	logic [`SNES_IO_ADDR_W-1:0] ioctl_addr;
	logic [`SNES_IO_DATA_W-1:0] ioctl_dout;
	logic                       ioctl_wr;
	snes_cart_pkg::hdr_mode_t   header_mode;
	logic [1:0]                 region_sel;
	logic [1:0]                 fill_pattern;
	logic                       img_mounted;
	logic                       img_readonly;
	logic [63:0]                img_size;
	logic                       bk_load_req;
	logic                       bk_save_req;
	logic                       sd_ack;
	logic [7:0]                 rom_type;
	logic [23:0]                rom_mask;
	logic [23:0]                ram_mask;
	logic                       pal;
	snes_cart_pkg::cheat_code_t cheat_code;
	logic                       cheat_strobe;
	logic                       clearing;
	logic                       fill_we;
	logic [FILL_BITS-1:0]       fill_addr;
	logic [7:0]                 fill_data;
	logic                       bk_ena;
	logic                       bk_busy;
	logic                       bk_loading;
	logic [31:0]                sd_lba;
	logic                       sd_rd;
	logic                       sd_wr;
	logic                       core_reset;

	int          check_count = 0;
	int          error_count = 0;
	int          test_errors = 0;
	int          strobe_count = 0;
	int          fill_writes;
	bit          fill_seen [0:(1<<FILL_BITS)-1];
	logic [15:0] code_words [0:7];

	snes_cart_top #(.FILL_BITS(FILL_BITS)) uut (.*);

	always #5 clk_sys = ~clk_sys;

	// Strobe pulses counted away from the active edge
	always @(negedge clk_sys) begin
		if (cheat_strobe)
			strobe_count++;
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s at time %0t", reason, $time);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic tick_timeout(inout int waited, input int limit, input string what);
		waited++;
		if (waited > limit)
			abort_run({"timed out waiting for ", what});
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %s, %0d errors", num, name,
			(error_count == test_errors) ? "ok" : "mismatch", error_count - test_errors);
		test_errors = error_count;
	endtask

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		ioctl_index = index;
		ioctl_download = 1'b1;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	task automatic write_word(input int addr, input logic [15:0] data);
		@(negedge clk_sys);
		ioctl_addr = `SNES_IO_ADDR_W'(addr);
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	// Power-on fill bytes by pattern and address
	function automatic logic [7:0] fill_expected(input logic [1:0] pattern,
		input logic [FILL_BITS-1:0] addr);
		case (pattern)
			2'd0: return (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			2'd1: return (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// Follows a clear sweep to its end while core reset holds
	task automatic follow_sweep(input bit check_fill, input bit drop_dl);
		int waited;
		int missing;
		waited = 0;
		missing = 0;
		fill_writes = 0;
		foreach (fill_seen[i])
			fill_seen[i] = 1'b0;
		@(negedge clk_sys);
		while (!clearing) begin
			tick_timeout(waited, 8, "the clear sweep to start");
			@(negedge clk_sys);
		end
		while (clearing) begin
			check_value(core_reset, 1'b1, "core_reset during sweep");
			if (check_fill && fill_we) begin
				check_value(fill_data, fill_expected(fill_pattern, fill_addr), "fill_data");
				fill_seen[fill_addr] = 1'b1;
				fill_writes++;
			end
			if (drop_dl)
				ioctl_download = 1'b0;
			tick_timeout(waited, SWEEP_LIMIT, "the clear sweep to finish");
			@(negedge clk_sys);
		end
		check_value(core_reset, 1'b0, "core_reset after sweep");
		if (check_fill) begin
			foreach (fill_seen[i])
				if (!fill_seen[i])
					missing++;
			check_value(fill_writes, 1 << FILL_BITS, "fill write count");
			check_value(missing, 0, "addresses never written");
		end
	endtask

	// Host side of one backup transfer with random sd_ack latency
	task automatic run_transfer(input bit load, input logic [31:0] last_lba);
		int   waited;
		logic [31:0] lba;
		bit   done;
		lba = 0;
		done = 1'b0;
		@(negedge clk_sys);
		bk_load_req = load;
		bk_save_req = !load;
		@(negedge clk_sys);
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		while (!done) begin
			waited = 0;
			while (!(load ? sd_rd : sd_wr)) begin
				tick_timeout(waited, 20, "a sector request");
				@(negedge clk_sys);
			end
			check_value(sd_lba, lba, "sd_lba");
			check_value(load ? sd_wr : sd_rd, 1'b0, "opposite sector request");
			repeat ($urandom_range(6, 0)) @(negedge clk_sys);
			sd_ack = 1'b1;
			waited = 0;
			@(negedge clk_sys);
			while (load ? sd_rd : sd_wr) begin
				tick_timeout(waited, 4, "the request to drop");
				@(negedge clk_sys);
			end
			repeat ($urandom_range(3, 0)) @(negedge clk_sys);
			sd_ack = 1'b0;
			waited = 0;
			@(negedge clk_sys);
			while (bk_busy && !(load ? sd_rd : sd_wr)) begin
				tick_timeout(waited, 4, "the next sector or the end of transfer");
				@(negedge clk_sys);
			end
			if (!bk_busy)
				done = 1'b1;
			else
				lba++;
		end
		check_value(lba, last_lba, "last sector transferred");
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		int          waited;
		int          strobes_before;
		logic [31:0] last_lba;
		void'($urandom(75659));
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = snes_cart_pkg::hdr_auto;
		region_sel = 2'd0;
		fill_pattern = 2'd0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 64'd0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		sd_ack = 1'b0;
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;

		// Auto mode with type 2, ROM size 8, RAM size 1 and region set
		start_download(8'h00);
		write_word(0, 16'h0218);
		write_word(2, 16'h0100);
		write_word(4, 16'h1234);
		end_download();
		follow_sweep(1'b0, 1'b0);
		check_value(rom_type, 8'h02, "rom_type");
		check_value(rom_mask, (24'd1024 << 8) - 24'd1, "rom_mask");
		check_value(ram_mask, (24'd1024 << 1) - 24'd1, "ram_mask");
		check_value(pal, 1'b1, "pal from header");
		finish_test(1, "auto header");

		header_mode = snes_cart_pkg::hdr_hirom;
		start_download(8'h00);
		write_word(0, 16'h0218);
		write_word(2, 16'h0000);
		write_word(32'hFFD6 + 512, 16'h0A00);
		write_word(32'hFFD8 + 512, 16'h0003);
		end_download();
		follow_sweep(1'b0, 1'b0);
		check_value(rom_type, 8'h01, "rom_type");
		check_value(rom_mask, (24'd1024 << 10) - 24'd1, "rom_mask");
		check_value(ram_mask, (24'd1024 << 3) - 24'd1, "ram_mask");
		check_value(pal, 1'b0, "pal from header");
		region_sel = 2'd2;
		@(negedge clk_sys);
		@(negedge clk_sys);
		check_value(pal, 1'b1, "pal forced by region_sel");
		region_sel = 2'd0;
		finish_test(2, "hirom header");

		strobes_before = strobe_count;
		start_download(8'hFF);
		for (int k = 0; k < 8; k++) begin
			code_words[k] = 16'($urandom());
			write_word(2 * k, code_words[k]);
		end
		end_download();
		waited = 0;
		while (strobe_count == strobes_before) begin
			tick_timeout(waited, 8, "cheat_strobe");
			@(negedge clk_sys);
		end
		repeat (3) @(negedge clk_sys);
		check_value(strobe_count - strobes_before, 1, "cheat_strobe pulses");
		check_value(cheat_code.fields.flags, {code_words[1], code_words[0]}, "flags");
		check_value(cheat_code.fields.addr, {code_words[3], code_words[2]}, "addr");
		check_value(cheat_code.fields.compare, {code_words[5], code_words[4]}, "compare");
		check_value(cheat_code.fields.replace, {code_words[7], code_words[6]}, "replace");
		finish_test(3, "cheat code");

		// One-cycle download per pattern without header words
		for (int p = 0; p < 4; p++) begin
			fill_pattern = 2'(p);
			start_download(8'h00);
			follow_sweep(1'b1, 1'b1);
		end
		finish_test(4, "clear sweep");

		start_download(8'h00);
		repeat (16) begin
			@(negedge clk_sys);
			check_value(core_reset, 1'b1, "core_reset during download");
		end
		end_download();
		follow_sweep(1'b0, 1'b0);
		finish_test(6, "core reset");

		// Writable image mounted while the cartridge loads
		header_mode = snes_cart_pkg::hdr_auto;
		img_mounted = 1'b1;
		start_download(8'h00);
		write_word(0, 16'h0218);
		end_download();
		img_mounted = 1'b0;
		follow_sweep(1'b0, 1'b0);
		check_value(bk_ena, 1'b1, "bk_ena");
		last_lba = 32'(((24'd1024 << 1) - 24'd1) >> 9);
		run_transfer(1'b0, last_lba);
		run_transfer(1'b1, last_lba);
		check_value(bk_loading, 1'b0, "bk_loading after load");
		finish_test(5, "backup save and load");

		repeat (4) @(negedge clk_sys);
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, uut.u_checker.fail_count);
		if (error_count == 0 && uut.u_checker.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== snes_cart_top.sv ====
// Cartridge ingest top. Decodes the download kind and feeds the header
// detector, cheat loader, RAM clear engine and backup sequencer.
// core_reset holds the console in reset while any of them is busy.

`default_nettype none

`include "snes_cart_settings.svh"

module snes_cart_top #(
	parameter int FILL_BITS = `SNES_FILL_BITS
) (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic [`SNES_IO_ADDR_W-1:0] ioctl_addr,
	input  logic [`SNES_IO_DATA_W-1:0] ioctl_dout,
	input  logic                       ioctl_wr,
	input  snes_cart_pkg::hdr_mode_t   header_mode,
	input  logic [1:0]                 region_sel,
	input  logic [1:0]                 fill_pattern,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic [63:0]                img_size,
	input  logic                       bk_load_req,
	input  logic                       bk_save_req,
	input  logic                       sd_ack,
	output logic [7:0]                 rom_type,
	output logic [`SNES_MASK_W-1:0]    rom_mask,
	output logic [`SNES_MASK_W-1:0]    ram_mask,
	output logic                       pal,
	output snes_cart_pkg::cheat_code_t cheat_code,
	output logic                       cheat_strobe,
	output logic                       clearing,
	output logic                       fill_we,
	output logic [FILL_BITS-1:0]       fill_addr,
	output logic [7:0]                 fill_data,
	output logic                       bk_ena,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic [31:0]                sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       core_reset
);

	snes_cart_pkg::dl_kind_t dl_kind;
	logic                    cart_dl;
	logic                    spc_dl;
	logic                    code_dl;

	// Download decode
	assign dl_kind = snes_cart_pkg::download_kind(ioctl_download, ioctl_index);
	assign cart_dl = (dl_kind == snes_cart_pkg::dl_cart);
	assign spc_dl = (dl_kind == snes_cart_pkg::dl_spc);
	assign code_dl = (dl_kind == snes_cart_pkg::dl_code);

	cart_header_detect u_header (
		.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .header_mode(header_mode),
		.region_sel(region_sel), .rom_type(rom_type), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .pal(pal)
	);

	cheat_code_loader u_cheat (
		.clk_sys(clk_sys), .RESET(RESET), .code_dl(code_dl), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr[3:0]), .ioctl_dout(ioctl_dout),
		.cheat_code(cheat_code), .cheat_strobe(cheat_strobe)
	);

	ram_clear_engine #(.FILL_BITS(FILL_BITS)) u_clear (
		.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl), .fill_pattern(fill_pattern),
		.clearing(clearing), .fill_we(fill_we), .fill_addr(fill_addr), .fill_data(fill_data)
	);

	backup_sector_seq u_backup (
		.clk_sys(clk_sys), .RESET(RESET), .cart_dl(cart_dl), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size(img_size), .rom_type(rom_type),
		.ram_mask(ram_mask), .bk_load_req(bk_load_req), .bk_save_req(bk_save_req),
		.sd_ack(sd_ack), .bk_ena(bk_ena), .bk_busy(bk_busy), .bk_loading(bk_loading),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr)
	);

	// Console stays in reset while memory is being filled or restored
	assign core_reset = RESET | cart_dl | spc_dl | bk_loading | clearing;

endmodule

`default_nettype wire
